// File: Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_aes_enc
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/aes_enc_top.sv
`timescale 1ns/10ps
`default_nettype none

module aes_enc_top (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire aes_pkg::block_t key,
    input  wire logic            key_load,
    output logic                 key_ready,
    input  wire aes_pkg::block_t block_in,
    input  wire logic            in_valid,
    output aes_pkg::block_t      block_out,
    output logic                 out_valid
);
    import aes_pkg::*;

    round_keys_t round_keys;
    block_t      mid_state;
    logic        mid_valid;

    key_schedule u_key_schedule (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .key_load   (key_load),
        .round_keys (round_keys),
        .key_ready  (key_ready)
    );

    // Keys 0 to 9 feed the pipeline, key 10 the final round
    round_pipeline u_round_pipeline (
        .clk        (clk),
        .rst        (rst),
        .block_in   (block_in),
        .in_valid   (in_valid),
        .key_ready  (key_ready),
        .round_keys (round_keys[NUM_ROUNDS-1:0]),
        .mid_state  (mid_state),
        .mid_valid  (mid_valid)
    );

    output_stage u_output_stage (
        .clk        (clk),
        .rst        (rst),
        .mid_state  (mid_state),
        .mid_valid  (mid_valid),
        .final_key  (round_keys[NUM_ROUNDS]),
        .block_out  (block_out),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// File: design/aes_pkg.sv
`default_nettype none

package aes_pkg;

    typedef logic [127:0] block_t;
    typedef logic [7:0]   byte_t;

    localparam int NUM_ROUNDS = 10;

    // Entry 0 is the cipher key itself
    typedef block_t [NUM_ROUNDS:0] round_keys_t;

    typedef enum logic [1:0] {
        KS_IDLE,
        KS_EXPAND,
        KS_READY
    } ks_state_t;

    localparam byte_t RCON [1:NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    function automatic byte_t gf_mul2(input byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t x;
        acc = '0;
        x   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc ^= x;
            end
            x = gf_mul2(x);
        end
        return acc;
    endfunction

    function automatic byte_t sbox(input byte_t a);
        byte_t sq;
        byte_t inv;
        // Multiplicative inverse as a^254, zero stays zero
        sq  = a;
        inv = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        // Affine transform
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic block_t sub_bytes(input block_t s);
        block_t res;
        for (int k = 0; k < 16; k++) begin
            res[8*k +: 8] = sbox(s[8*k +: 8]);
        end
        return res;
    endfunction

    // Byte k of the state sits at bits [127-8k -: 8], column major
    function automatic block_t shift_rows(input block_t s);
        block_t res;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[127 - 8*(4*c + r) -: 8] = s[127 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
        return res;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t      res;
        logic [31:0] col;
        for (int c = 0; c < 4; c++) begin
            col = s[127 - 32*c -: 32];
            res[127 - 32*c -: 8] = gf_mul2(col[31:24]) ^ gf_mul2(col[23:16]) ^ col[23:16]
                                 ^ col[15:8] ^ col[7:0];
            res[119 - 32*c -: 8] = col[31:24] ^ gf_mul2(col[23:16]) ^ gf_mul2(col[15:8])
                                 ^ col[15:8] ^ col[7:0];
            res[111 - 32*c -: 8] = col[31:24] ^ col[23:16] ^ gf_mul2(col[15:8])
                                 ^ gf_mul2(col[7:0]) ^ col[7:0];
            res[103 - 32*c -: 8] = gf_mul2(col[31:24]) ^ col[31:24] ^ col[23:16]
                                 ^ col[15:8] ^ gf_mul2(col[7:0]);
        end
        return res;
    endfunction

    function automatic block_t next_round_key(input block_t prev, input byte_t rcon);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [31:0] t;
        w0 = prev[127:96];
        w1 = prev[95:64];
        w2 = prev[63:32];
        w3 = prev[31:0];
        // RotWord then SubWord on the last word
        t  = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};
        t  = t ^ {rcon, 24'h000000};
        w0 = w0 ^ t;
        w1 = w1 ^ w0;
        w2 = w2 ^ w1;
        w3 = w3 ^ w2;
        return {w0, w1, w2, w3};
    endfunction

endpackage

`default_nettype wire

// File: design/aes_round.sv
`timescale 1ns/10ps
`default_nettype none

module aes_round #(
    parameter bit FINAL = 1'b0
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire aes_pkg::block_t state_in,
    input  wire logic            valid_in,
    input  wire aes_pkg::block_t round_key,
    output aes_pkg::block_t      state_out,
    output logic                 valid_out
);
    import aes_pkg::*;

    block_t shifted;
    block_t mixed;

    assign shifted = shift_rows(sub_bytes(state_in));

    // Last round of the cipher skips MixColumns
    assign mixed = FINAL ? shifted : mix_columns(shifted);

    always_ff @(posedge clk) begin
        state_out <= mixed ^ round_key;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

endmodule

`default_nettype wire

// File: design/key_schedule.sv
`timescale 1ns/10ps
`default_nettype none

module key_schedule (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire aes_pkg::block_t     key,
    input  wire logic                key_load,
    output aes_pkg::round_keys_t     round_keys,
    output logic                     key_ready
);
    import aes_pkg::*;

    ks_state_t  state;
    logic [3:0] round_idx;
    logic       load_accept;

    // Strobes during expansion are ignored
    assign load_accept = key_load && (state != KS_EXPAND);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= KS_IDLE;
            round_idx <= '0;
            key_ready <= 1'b0;
        end else begin
            case (state)
                KS_IDLE, KS_READY: begin
                    if (load_accept) begin
                        state     <= KS_EXPAND;
                        round_idx <= 4'd1;
                        key_ready <= 1'b0;
                    end else if (state == KS_READY) begin
                        key_ready <= 1'b1;
                    end
                end
                KS_EXPAND: begin
                    if (round_idx == 4'(NUM_ROUNDS)) begin
                        state     <= KS_READY;
                        round_idx <= '0;
                    end else begin
                        round_idx <= round_idx + 4'd1;
                    end
                end
                default: begin
                    state <= KS_IDLE;
                end
            endcase
        end
    end

    // One expansion step per cycle, each from the previous entry
    always_ff @(posedge clk) begin
        if (load_accept) begin
            round_keys[0] <= key;
        end else if (state == KS_EXPAND) begin
            round_keys[round_idx] <= next_round_key(round_keys[round_idx - 4'd1],
                                                    RCON[round_idx]);
        end
    end

    a_ready_only_when_done: assert property (
        @(posedge clk) disable iff (!rst)
        key_ready |-> (state == KS_READY)
    );

    a_round_idx_range: assert property (
        @(posedge clk) disable iff (!rst)
        round_idx <= 4'(NUM_ROUNDS)
    );

endmodule

`default_nettype wire

// File: design/output_stage.sv
`timescale 1ns/10ps
`default_nettype none

module output_stage (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire aes_pkg::block_t mid_state,
    input  wire logic            mid_valid,
    input  wire aes_pkg::block_t final_key,
    output aes_pkg::block_t      block_out,
    output logic                 out_valid
);
    import aes_pkg::*;

    block_t final_state;
    logic   final_valid;

    aes_round #(
        .FINAL (1'b1)
    ) u_final (
        .clk       (clk),
        .rst       (rst),
        .state_in  (mid_state),
        .valid_in  (mid_valid),
        .round_key (final_key),
        .state_out (final_state),
        .valid_out (final_valid)
    );

    // Output register, zero between results
    always_ff @(posedge clk) begin
        if (!rst) begin
            block_out <= '0;
            out_valid <= 1'b0;
        end else begin
            block_out <= final_valid ? final_state : '0;
            out_valid <= final_valid;
        end
    end

    a_zero_when_idle: assert property (
        @(posedge clk) disable iff (!rst)
        !out_valid |-> (block_out == '0)
    );

endmodule

`default_nettype wire

// File: design/round_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module round_pipeline (
    input  wire logic                                       clk,
    input  wire logic                                       rst,
    input  wire aes_pkg::block_t                            block_in,
    input  wire logic                                       in_valid,
    input  wire logic                                       key_ready,
    input  wire aes_pkg::block_t [aes_pkg::NUM_ROUNDS-1:0]  round_keys,
    output aes_pkg::block_t                                 mid_state,
    output logic                                            mid_valid
);
    import aes_pkg::*;

    block_t ark_state;
    logic   ark_valid;

    // Stage 0 is the initial AddRoundKey and stages 1 to 9 are full rounds
    block_t stage_state [NUM_ROUNDS];
    logic   stage_valid [NUM_ROUNDS];

    always_ff @(posedge clk) begin
        ark_state <= block_in ^ round_keys[0];
    end

    // Blocks offered before the keys are ready are dropped
    always_ff @(posedge clk) begin
        if (!rst) begin
            ark_valid <= 1'b0;
        end else begin
            ark_valid <= in_valid && key_ready;
        end
    end

    assign stage_state[0] = ark_state;
    assign stage_valid[0] = ark_valid;

    for (genvar i = 1; i < NUM_ROUNDS; i++) begin : g_round
        aes_round #(
            .FINAL (1'b0)
        ) u_round (
            .clk       (clk),
            .rst       (rst),
            .state_in  (stage_state[i-1]),
            .valid_in  (stage_valid[i-1]),
            .round_key (round_keys[i]),
            .state_out (stage_state[i]),
            .valid_out (stage_valid[i])
        );
    end

    assign mid_state = stage_state[NUM_ROUNDS-1];
    assign mid_valid = stage_valid[NUM_ROUNDS-1];

    // A valid leaving the chain entered it while the keys were ready
    a_no_entry_without_keys: assert property (
        @(posedge clk) disable iff (!rst)
        mid_valid |-> $past(key_ready, NUM_ROUNDS)
    );

endmodule

`default_nettype wire

// File: verif/aes_ref_model.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// Behavioral AES-128 encryption built from the FIPS-197 round steps.
// Included inside the testbench module after the package import.

// Full key expansion, entry 0 is the cipher key
function automatic round_keys_t expand_cipher_key(input block_t cipher_key);
    round_keys_t rk;
    rk[0] = cipher_key;
    for (int r = 1; r <= NUM_ROUNDS; r++) begin
        rk[r] = next_round_key(rk[r-1], RCON[r]);
    end
    return rk;
endfunction

// One block through all ten rounds, no pipelining
function automatic block_t encrypt_block(input block_t cipher_key, input block_t plain);
    round_keys_t rk;
    block_t      state;
    rk    = expand_cipher_key(cipher_key);
    state = plain ^ rk[0];
    for (int r = 1; r <= NUM_ROUNDS; r++) begin
        state = sub_bytes(state);
        state = shift_rows(state);
        // Last round has no MixColumns
        if (r != NUM_ROUNDS) begin
            state = mix_columns(state);
        end
        state = state ^ rk[r];
    end
    return state;
endfunction

`endif

// File: verif/tb_aes_enc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_aes_enc;
    import aes_pkg::*;

    `include "aes_ref_model.svh"

    localparam int NUM_VECTORS = 3;
    localparam int NUM_RANDOM  = 64;
    localparam int LATENCY     = 11;
    localparam int MAX_CYCLES  = 3 * (3 * 25 + 64 + 40);

    typedef struct packed {
        block_t key;
        block_t plain;
        block_t cipher;
    } vector_t;

    // FIPS-197 C.1 and Appendix B vectors plus an all-zero key and block
    vector_t vectors [NUM_VECTORS] = '{
        '{128'h000102030405060708090a0b0c0d0e0f,
          128'h00112233445566778899aabbccddeeff,
          128'h69c4e0d86a7b0430d8cdb78070b4c55a},
        '{128'h2b7e151628aed2a6abf7158809cf4f3c,
          128'h3243f6a8885a308d313198a2e0370734,
          128'h3925841d02dc09fbdc118597196a0b32},
        '{128'h00000000000000000000000000000000,
          128'h00000000000000000000000000000000,
          128'h66e94bd4ef8a2c3b884cfa59ca342b2e}
    };

    logic   clk = 1'b0;
    logic   rst;
    block_t key;
    logic   key_load;
    logic   key_ready;
    block_t block_in;
    logic   in_valid;
    block_t block_out;
    logic   out_valid;

    int          cycle_cnt = 0;
    logic        monitor_on = 1'b0;
    logic [31:0] rng_state = 32'h9bd8;

    // Scoreboard of expected blocks and the cycles they are due
    block_t exp_q [$];
    int     due_q [$];

    aes_enc_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .key_load  (key_load),
        .key_ready (key_ready),
        .block_in  (block_in),
        .in_valid  (in_valid),
        .block_out (block_out),
        .out_valid (out_valid)
    );

    always #10 clk = ~clk;

    task automatic report_error(input string text);
        $display("%s", text);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_block(input string name, input block_t actual, input block_t expected);
        if (actual !== expected) begin
            report_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                   $time, name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_error($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                                   $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_block(output block_t b);
        for (int w = 0; w < 4; w++) begin
            rng_state = xorshift32(rng_state);
            b[32*w +: 32] = rng_state;
        end
    endtask

    // Called on a falling edge and may strobe key_load again mid expansion
    task automatic load_key(input block_t new_key, input logic poke_during_expand);
        key      = new_key;
        key_load = 1'b1;
        @(negedge clk);
        key_load = 1'b0;
        for (int i = 0; i < LATENCY; i++) begin
            check_bit("key_ready", key_ready, 1'b0);
            if (poke_during_expand && i == 4) begin
                key      = ~new_key;
                key_load = 1'b1;
            end
            @(negedge clk);
            key_load = 1'b0;
        end
        check_bit("key_ready", key_ready, 1'b1);
    endtask

    // Blocks offered while key_ready is low are not expected back
    task automatic send_block(input block_t plain, input block_t expected,
                              input logic accepted);
        check_bit("key_ready", key_ready, accepted);
        block_in = plain;
        in_valid = 1'b1;
        if (accepted) begin
            exp_q.push_back(expected);
            due_q.push_back(cycle_cnt + 1 + LATENCY);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (due_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_error($sformatf("Timeout, the run did not finish within %0d cycles",
                                   MAX_CYCLES));
        end
    end

    // Output must stay zero on every cycle without a due result
    always @(negedge clk) begin
        if (monitor_on) begin
            if (due_q.size() != 0 && due_q[0] == cycle_cnt) begin
                check_bit("out_valid", out_valid, 1'b1);
                check_block("block_out", block_out, exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                check_bit("out_valid", out_valid, 1'b0);
                check_block("block_out", block_out, '0);
            end
        end
    end

    initial begin : stimulus
        block_t plain;
        rst      = 1'b0;
        key      = '0;
        key_load = 1'b0;
        block_in = '0;
        in_valid = 1'b0;

        // Anchor the model to the standard vectors first
        for (int v = 0; v < NUM_VECTORS; v++) begin
            check_block("reference model", encrypt_block(vectors[v].key, vectors[v].plain),
                        vectors[v].cipher);
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check_bit("key_ready", key_ready, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
        check_block("block_out", block_out, '0);
        monitor_on = 1'b1;

        // No key yet so this block is dropped
        send_block(vectors[0].plain, vectors[0].cipher, 1'b0);
        repeat (LATENCY + 1) @(negedge clk);

        for (int v = 0; v < NUM_VECTORS; v++) begin
            load_key(vectors[v].key, v == 0);
            send_block(vectors[v].plain, vectors[v].cipher, 1'b1);
            wait_drain();
        end

        // Back to back stream under the Appendix B key
        load_key(vectors[1].key, 1'b0);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_block(plain);
            send_block(plain, encrypt_block(vectors[1].key, plain), 1'b1);
        end
        wait_drain();

        // Reload with a block offered during expansion and then use the new key
        fork
            load_key(vectors[0].key, 1'b0);
            begin
                repeat (3) @(negedge clk);
                send_block(vectors[2].plain, vectors[2].cipher, 1'b0);
            end
        join
        send_block(vectors[0].plain, vectors[0].cipher, 1'b1);
        wait_drain();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verif
design/aes_pkg.sv
design/key_schedule.sv
design/aes_round.sv
design/round_pipeline.sv
design/output_stage.sv
design/aes_enc_top.sv
verif/tb_aes_enc.sv
